// File: wb_stage.f
verilog/wb_pkg.sv
verilog/wb_flags.sv
verilog/wb_commit.sv
verilog/wb_store_buffer.sv
verilog/wb_apb_store.sv
verilog/wb_regfile.sv
verilog/wb_stage.sv
tests/wb_stage_assertions.sv
tests/wb_stage_tb.sv

// File: Bender.yml
package:
  name: wb_stage

sources:
  - verilog/wb_pkg.sv
  - verilog/wb_flags.sv
  - verilog/wb_commit.sv
  - verilog/wb_store_buffer.sv
  - verilog/wb_apb_store.sv
  - verilog/wb_regfile.sv
  - verilog/wb_stage.sv
  - target: test
    files:
      - tests/wb_stage_assertions.sv
      - tests/wb_stage_tb.sv

// File: tests/wb_stage_tb.sv
`timescale 1ns/1ps

module wb_stage_tb import wb_pkg::*; ();

   localparam int RESET_CYCLES = 10;
   localparam int TOTAL_UOPS   = 45;

   logic                  CLK;
   logic                  rst_n;
   wb_uop_t               uop;
   logic                  stall;
   logic                  halted;
   logic [DATA_W-1:0]     flags_fwd;
   logic [DATA_W-1:0]     eip;
   logic [GPR_ADDR_W-1:0] rd_addr1;
   logic [DATA_W-1:0]     rd_data1;
   logic [GPR_ADDR_W-1:0] rd_addr2;
   logic [DATA_W-1:0]     rd_data2;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [ADDR_W-1:0]     paddr;
   logic [DATA_W-1:0]     pwdata;
   logic                  pready;
   logic                  pslverr;

   // reference model state
   logic [DATA_W-1:0] ref_gpr [GPR_COUNT];
   logic [DATA_W-1:0] ref_eip = '0;
   logic [DATA_W-1:0] ref_flags = '0;
   logic              ref_halted = 1'b0;
   wb_store_t         exp_q [$];
   wb_store_t         exp_store;

   int          errors = 0;
   int          apb_writes = 0;
   int          wait_cnt = 0;
   logic        slow_slave = 1'b0;
   logic        stall_seen = 1'b0;
   logic [31:0] data_seed = 32'd68463;
   logic [31:0] wait_seed = 32'd68463;
   string       test_name = "reset";

   wb_stage dut_i (.*);

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   function automatic logic [31:0] next_random(inout logic [31:0] state);
      state = state * 32'd1103515245 + 32'd12345;
      // upper half carries the better bits of the sequence
      return {state[15:0], state[31:16]};
   endfunction

   function automatic wb_uop_t blank_uop();
      wb_uop_t u;
      u = '0;
      u.valid = 1'b1;
      return u;
   endfunction

   task automatic compare(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      assert (actual === expected) else begin
         errors++;
         $display("mismatch %s: %s expected %h actual %h", test_name, what, expected, actual);
      end
   endtask

   task automatic apply_model(input wb_uop_t u);
      logic cur_zf;
      logic cur_cf;
      wb_store_t req;
      cur_zf = ref_flags[FLAG_ZF];
      cur_cf = ref_flags[FLAG_CF];
      if (!u.valid || ref_halted) return;
      if (u.ld_gpr1) ref_gpr[u.dr1] = u.result_a;
      // port 2 after port 1 so it wins on the same register
      if (u.ld_gpr2 && (!u.is_cmovc || cur_cf)) ref_gpr[u.dr2] = u.result_b;
      if (u.ld_eip && (!u.is_jne || !cur_zf)) ref_eip = u.neip;
      if (u.ld_flags) begin
         for (int b = 0; b < DATA_W; b++) begin
            if (u.flags_mask[b]) ref_flags[b] = u.flags_in[b];
         end
      end
      if (u.dcache_write) begin
         req.addr = u.address;
         req.data = u.result_a;
         exp_q.push_back(req);
      end
      if (u.is_halt) ref_halted = 1'b1;
   endtask

   // hold the micro-op until it gets past stall, then let one edge take it
   task automatic issue(input wb_uop_t u);
      @(negedge CLK);
      uop = u;
      #1;
      while (stall) begin
         @(negedge CLK);
         #1;
      end
      @(posedge CLK);
      apply_model(u);
   endtask

   task automatic drop_uop();
      @(negedge CLK);
      uop = '0;
   endtask

   task automatic check_state();
      for (int i = 0; i < GPR_COUNT; i++) begin
         rd_addr1 = GPR_ADDR_W'(i);
         rd_addr2 = GPR_ADDR_W'(GPR_COUNT - 1 - i);
         #0.25;
         compare($sformatf("gpr%0d on port 1", i), ref_gpr[i], rd_data1);
         compare($sformatf("gpr%0d on port 2", GPR_COUNT - 1 - i),
                 ref_gpr[GPR_COUNT - 1 - i], rd_data2);
      end
      compare("eip", ref_eip, eip);
      compare("flags", ref_flags, flags_fwd);
      compare("halted", 32'(ref_halted), 32'(halted));
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || psel) begin
         @(negedge CLK);
      end
   endtask

   // APB slave model picking its wait states in the setup cycle
   always @(negedge CLK) begin
      if (psel && !penable) begin
         wait_cnt = slow_slave ? 3 : int'(next_random(wait_seed) % 4);
         pready = 1'b0;
         pslverr = 1'b0;
      end else if (psel && penable) begin
         pready = (wait_cnt == 0);
         pslverr = (wait_cnt == 0) && wait_seed[20];
         if (wait_cnt != 0) wait_cnt--;
      end else begin
         pready = 1'b0;
         pslverr = 1'b0;
      end
   end

   always @(posedge CLK) begin
      if (rst_n && psel && penable && pready) begin
         apb_writes++;
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("APB write to %h in %s with no store outstanding", paddr, test_name);
         end
         if (exp_q.size() != 0) begin
            exp_store = exp_q.pop_front();
            compare("store address", exp_store.addr, paddr);
            compare("store data", exp_store.data, pwdata);
         end
      end
      if (stall) stall_seen <= 1'b1;
   end

   initial begin
      repeat (RESET_CYCLES + 200 * TOTAL_UOPS) @(posedge CLK);
      $display("watchdog expired during test %s", test_name);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      wb_uop_t     u;
      logic [31:0] r;
      uop      = '0;
      rst_n    = 1'b0;
      rd_addr1 = '0;
      rd_addr2 = '0;
      pready   = 1'b0;
      pslverr  = 1'b0;
      for (int i = 0; i < GPR_COUNT; i++) begin
         ref_gpr[i] = '0;
      end
      repeat (RESET_CYCLES) @(negedge CLK);
      rst_n = 1'b1;
      check_state();

      test_name = "regs";
      for (int i = 0; i < GPR_COUNT; i++) begin
         u = blank_uop();
         u.ld_gpr1  = 1'b1;
         u.dr1      = GPR_ADDR_W'(i);
         u.result_a = next_random(data_seed);
         u.ld_gpr2  = 1'b1;
         u.dr2      = GPR_ADDR_W'(next_random(data_seed));
         u.result_b = next_random(data_seed);
         issue(u);
      end
      // both ports on one register
      u.dr1 = GPR_ADDR_W'(3);
      u.dr2 = GPR_ADDR_W'(3);
      issue(u);
      drop_uop();
      check_state();

      test_name = "flags";
      for (int i = 0; i < 5; i++) begin
         u = blank_uop();
         u.valid      = (i != 4);
         u.ld_flags   = 1'b1;
         u.flags_mask = next_random(data_seed);
         u.flags_in   = next_random(data_seed);
         u.ld_gpr1    = 1'b1;
         u.result_a   = next_random(data_seed);
         issue(u);
         drop_uop();
         check_state();
      end

      test_name = "jne_cmovc";
      for (int i = 0; i < 12; i++) begin
         r = next_random(data_seed);
         u = blank_uop();
         u.ld_flags   = r[0];
         u.flags_mask = (32'(r[1]) << FLAG_CF) | (32'(r[2]) << FLAG_ZF);
         u.flags_in   = (32'(r[3]) << FLAG_CF) | (32'(r[4]) << FLAG_ZF);
         u.is_jne     = 1'b1;
         u.ld_eip     = 1'b1;
         u.neip       = next_random(data_seed);
         u.is_cmovc   = 1'b1;
         u.ld_gpr2    = 1'b1;
         u.dr2        = GPR_ADDR_W'(i);
         u.result_b   = next_random(data_seed);
         issue(u);
         drop_uop();
         check_state();
      end

      test_name = "stores";
      for (int i = 0; i < 8; i++) begin
         u = blank_uop();
         u.dcache_write = 1'b1;
         u.address      = next_random(data_seed);
         u.result_a     = next_random(data_seed);
         issue(u);
      end
      drop_uop();
      wait_drain();

      test_name = "burst";
      slow_slave = 1'b1;
      stall_seen = 1'b0;
      for (int i = 0; i < 6; i++) begin
         u = blank_uop();
         u.dcache_write = 1'b1;
         u.address      = 32'h1000 + 32'(4 * i);
         u.ld_gpr1      = 1'b1;
         u.dr1          = GPR_ADDR_W'(i);
         u.result_a     = next_random(data_seed);
         issue(u);
      end
      drop_uop();
      wait_drain();
      assert (stall_seen) else begin
         errors++;
         $display("stall never rose during the store burst");
      end
      slow_slave = 1'b0;
      check_state();

      test_name = "halt";
      u = blank_uop();
      u.is_halt  = 1'b1;
      u.ld_gpr1  = 1'b1;
      u.dr1      = GPR_ADDR_W'(7);
      u.result_a = next_random(data_seed);
      issue(u);
      for (int i = 0; i < 4; i++) begin
         u = blank_uop();
         u.ld_gpr1    = 1'b1;
         u.dr1        = GPR_ADDR_W'(i);
         u.result_a   = next_random(data_seed);
         u.ld_flags   = 1'b1;
         u.flags_mask = '1;
         u.flags_in   = next_random(data_seed);
         u.ld_eip     = 1'b1;
         u.neip       = next_random(data_seed);
         issue(u);
      end
      drop_uop();
      check_state();

      $display("checks failed: %0d, assertion failures: %0d, APB writes: %0d",
               errors, dut_i.assertions_i.fail_count, apb_writes);
      if (errors == 0 && dut_i.assertions_i.fail_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: tests/wb_stage_assertions.sv
`timescale 1ns/1ps

module wb_stage_assertions import wb_pkg::*; (
   input logic              CLK,
   input logic              rst_n,
   input wb_uop_t           uop,
   input logic              stall,
   input logic              halted,
   input logic              push,
   input logic              pop,
   input logic              gpr1_we,
   input logic              gpr2_we,
   input logic              eip_we,
   input logic              flags_we,
   input logic              psel,
   input logic              penable,
   input logic              pwrite,
   input logic [ADDR_W-1:0] paddr,
   input logic [DATA_W-1:0] pwdata,
   input logic              pready
);

   // read by the testbench at the end of the run
   int fail_count = 0;

   // store buffer occupancy rebuilt from its push and pop strobes
   int occupancy = 0;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         occupancy <= 0;
      end else begin
         occupancy <= occupancy + int'(push) - int'(pop);
      end
   end

   penable_after_setup: assert property (@(posedge CLK) disable iff (!rst_n)
      $rose(penable) |-> $past(psel) && psel) else begin
      fail_count++;
      $error("penable rose without a preceding setup cycle");
   end

   // setup and wait cycles keep the request steady
   request_stable: assert property (@(posedge CLK) disable iff (!rst_n)
      psel && !(penable && pready) |=> $stable(paddr) && $stable(pwdata)) else begin
      fail_count++;
      $error("paddr or pwdata changed before pready");
   end

   write_only: assert property (@(posedge CLK) disable iff (!rst_n) pwrite) else begin
      fail_count++;
      $error("pwrite dropped low");
   end

   no_write_when_halted: assert property (@(posedge CLK) disable iff (!rst_n)
      halted |-> !(gpr1_we || gpr2_we || eip_we || flags_we)) else begin
      fail_count++;
      $error("state written while halted");
   end

   stall_cause: assert property (@(posedge CLK) disable iff (!rst_n)
      stall |-> occupancy == STORE_DEPTH && uop.valid && uop.dcache_write) else begin
      fail_count++;
      $error("stall raised without a store against a full buffer");
   end

endmodule

bind wb_stage wb_stage_assertions assertions_i (.*);

// File: verilog/wb_stage.sv
`timescale 1ns/1ps

module wb_stage import wb_pkg::*; (
   input  logic                  CLK,
   input  logic                  rst_n,
   input  wb_uop_t               uop,
   output logic                  stall,
   output logic                  halted,
   output logic [DATA_W-1:0]     flags_fwd,
   output logic [DATA_W-1:0]     eip,
   input  logic [GPR_ADDR_W-1:0] rd_addr1,
   output logic [DATA_W-1:0]     rd_data1,
   input  logic [GPR_ADDR_W-1:0] rd_addr2,
   output logic [DATA_W-1:0]     rd_data2,
   output logic                  psel,
   output logic                  penable,
   output logic                  pwrite,
   output logic [ADDR_W-1:0]     paddr,
   output logic [DATA_W-1:0]     pwdata,
   input  logic                  pready,
   input  logic                  pslverr
);

   logic [DATA_W-1:0]     flags;
   logic                  buf_full;
   logic                  gpr1_we;
   logic [GPR_ADDR_W-1:0] gpr1_addr;
   logic [DATA_W-1:0]     gpr1_data;
   logic                  gpr2_we;
   logic [GPR_ADDR_W-1:0] gpr2_addr;
   logic [DATA_W-1:0]     gpr2_data;
   logic                  eip_we;
   logic [DATA_W-1:0]     eip_data;
   logic                  flags_we;
   logic [DATA_W-1:0]     flags_mask;
   logic [DATA_W-1:0]     flags_data;
   logic                  push;
   wb_store_t             push_data;
   logic                  pop;
   logic                  not_empty;
   wb_store_t             head;

   wb_commit u_commit (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .uop        (uop),
      .flags      (flags),
      .buf_full   (buf_full),
      .stall      (stall),
      .halted     (halted),
      .gpr1_we    (gpr1_we),
      .gpr1_addr  (gpr1_addr),
      .gpr1_data  (gpr1_data),
      .gpr2_we    (gpr2_we),
      .gpr2_addr  (gpr2_addr),
      .gpr2_data  (gpr2_data),
      .eip_we     (eip_we),
      .eip_data   (eip_data),
      .flags_we   (flags_we),
      .flags_mask (flags_mask),
      .flags_data (flags_data),
      .push       (push),
      .push_data  (push_data)
   );

   wb_flags u_flags (
      .CLK   (CLK),
      .rst_n (rst_n),
      .we    (flags_we),
      .mask  (flags_mask),
      .data  (flags_data),
      .flags (flags)
   );

   // forwarded flags are the register output itself
   assign flags_fwd = flags;

   wb_regfile u_regfile (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .gpr1_we   (gpr1_we),
      .gpr1_addr (gpr1_addr),
      .gpr1_data (gpr1_data),
      .gpr2_we   (gpr2_we),
      .gpr2_addr (gpr2_addr),
      .gpr2_data (gpr2_data),
      .eip_we    (eip_we),
      .eip_data  (eip_data),
      .rd_addr1  (rd_addr1),
      .rd_data1  (rd_data1),
      .rd_addr2  (rd_addr2),
      .rd_data2  (rd_data2),
      .eip       (eip)
   );

   wb_store_buffer u_store_buffer (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .push      (push),
      .push_data (push_data),
      .full      (buf_full),
      .pop       (pop),
      .not_empty (not_empty),
      .head      (head)
   );

   wb_apb_store u_apb_store (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .not_empty (not_empty),
      .head      (head),
      .pop       (pop),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .pready    (pready),
      .pslverr   (pslverr)
   );

endmodule

// File: verilog/wb_regfile.sv
`timescale 1ns/1ps

module wb_regfile import wb_pkg::*; (
   input  logic                  CLK,
   input  logic                  rst_n,
   input  logic                  gpr1_we,
   input  logic [GPR_ADDR_W-1:0] gpr1_addr,
   input  logic [DATA_W-1:0]     gpr1_data,
   input  logic                  gpr2_we,
   input  logic [GPR_ADDR_W-1:0] gpr2_addr,
   input  logic [DATA_W-1:0]     gpr2_data,
   input  logic                  eip_we,
   input  logic [DATA_W-1:0]     eip_data,
   input  logic [GPR_ADDR_W-1:0] rd_addr1,
   output logic [DATA_W-1:0]     rd_data1,
   input  logic [GPR_ADDR_W-1:0] rd_addr2,
   output logic [DATA_W-1:0]     rd_data2,
   output logic [DATA_W-1:0]     eip
);

   logic [DATA_W-1:0] gpr [GPR_COUNT];
   logic [DATA_W-1:0] eip_q;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         for (int i = 0; i < GPR_COUNT; i++) begin
            gpr[i] <= '0;
         end
         eip_q <= '0;
      end else begin
         if (gpr1_we) begin
            gpr[gpr1_addr] <= gpr1_data;
         end
         // later assignment wins, so port 2 beats port 1 on the same register
         if (gpr2_we) begin
            gpr[gpr2_addr] <= gpr2_data;
         end
         if (eip_we) begin
            eip_q <= eip_data;
         end
      end
   end

   // decode read ports without bypass of this cycle's write
   assign rd_data1 = gpr[rd_addr1];
   assign rd_data2 = gpr[rd_addr2];
   assign eip      = eip_q;

endmodule

// File: verilog/wb_apb_store.sv
`timescale 1ns/1ps

module wb_apb_store import wb_pkg::*; (
   input  logic              CLK,
   input  logic              rst_n,
   input  logic              not_empty,
   input  wb_store_t         head,
   output logic              pop,
   output logic              psel,
   output logic              penable,
   output logic              pwrite,
   output logic [ADDR_W-1:0] paddr,
   output logic [DATA_W-1:0] pwdata,
   input  logic              pready,
   input  logic              pslverr
);

   typedef enum logic [1:0] {
      APB_IDLE,
      APB_SETUP,
      APB_ACCESS
   } apb_state_t;

   apb_state_t state;
   apb_state_t state_next;
   wb_store_t  req_q;

   always_comb begin
      state_next = state;
      case (state)
         APB_IDLE:   if (not_empty) state_next = APB_SETUP;
         APB_SETUP:  state_next = APB_ACCESS;
         // the store retires on pready whatever pslverr says
         APB_ACCESS: if (pready) state_next = APB_IDLE;
         default:    state_next = APB_IDLE;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         state <= APB_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // capture the head once so address and data hold through wait states
   always_ff @(posedge CLK) begin
      if (state == APB_IDLE && not_empty) begin
         req_q <= head;
      end
   end

   assign psel    = (state != APB_IDLE);
   assign penable = (state == APB_ACCESS);
   assign pwrite  = 1'b1;
   assign paddr   = req_q.addr;
   assign pwdata  = req_q.data;

   assign pop = (state == APB_ACCESS) && pready;

endmodule

// File: verilog/wb_store_buffer.sv
`timescale 1ns/1ps

module wb_store_buffer import wb_pkg::*; (
   input  logic      CLK,
   input  logic      rst_n,
   input  logic      push,
   input  wb_store_t push_data,
   output logic      full,
   input  logic      pop,
   output logic      not_empty,
   output wb_store_t head
);

   wb_store_t               mem [STORE_DEPTH];
   logic [STORE_PTR_W-1:0] wr_ptr;
   logic [STORE_PTR_W-1:0] rd_ptr;
   logic [STORE_CNT_W-1:0] count;
   logic                   do_push;
   logic                   do_pop;

   function automatic logic [STORE_PTR_W-1:0] ptr_inc(input logic [STORE_PTR_W-1:0] ptr);
      if (ptr == STORE_PTR_W'(STORE_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full      = (count == STORE_CNT_W'(STORE_DEPTH));
   assign not_empty = (count != '0);

   assign do_push = push && !full;
   assign do_pop  = pop && not_empty;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // simultaneous push and pop leaves the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   assign head = mem[rd_ptr];

endmodule

// File: verilog/wb_commit.sv
`timescale 1ns/1ps

module wb_commit import wb_pkg::*; (
   input  logic                  CLK,
   input  logic                  rst_n,
   input  wb_uop_t               uop,
   input  logic [DATA_W-1:0]     flags,
   input  logic                  buf_full,
   output logic                  stall,
   output logic                  halted,
   output logic                  gpr1_we,
   output logic [GPR_ADDR_W-1:0] gpr1_addr,
   output logic [DATA_W-1:0]     gpr1_data,
   output logic                  gpr2_we,
   output logic [GPR_ADDR_W-1:0] gpr2_addr,
   output logic [DATA_W-1:0]     gpr2_data,
   output logic                  eip_we,
   output logic [DATA_W-1:0]     eip_data,
   output logic                  flags_we,
   output logic [DATA_W-1:0]     flags_mask,
   output logic [DATA_W-1:0]     flags_data,
   output logic                  push,
   output wb_store_t             push_data
);

   logic halted_q;
   logic accept;
   logic cond_jne;
   logic cond_cmovc;

   // store with no room left holds the whole micro-op in place
   assign stall = uop.valid && uop.dcache_write && buf_full;

   assign accept = uop.valid && !halted_q && !stall;

   // conditions look at flags before this micro-op updates them
   assign cond_jne   = !uop.is_jne   || !flags[FLAG_ZF];
   assign cond_cmovc = !uop.is_cmovc ||  flags[FLAG_CF];

   assign gpr1_we   = accept && uop.ld_gpr1;
   assign gpr1_addr = uop.dr1;
   assign gpr1_data = uop.result_a;

   assign gpr2_we   = accept && uop.ld_gpr2 && cond_cmovc;
   assign gpr2_addr = uop.dr2;
   assign gpr2_data = uop.result_b;

   assign eip_we   = accept && uop.ld_eip && cond_jne;
   assign eip_data = uop.neip;

   assign flags_we   = accept && uop.ld_flags;
   assign flags_mask = uop.flags_mask;
   assign flags_data = uop.flags_in;

   // store data comes from the A result, as the dcache write did
   assign push           = accept && uop.dcache_write;
   assign push_data.addr = uop.address;
   assign push_data.data = uop.result_a;

   // sticky halt cleared only by reset
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         halted_q <= 1'b0;
      end else if (accept && uop.is_halt) begin
         halted_q <= 1'b1;
      end
   end

   assign halted = halted_q;

endmodule

// File: verilog/wb_flags.sv
`timescale 1ns/1ps

module wb_flags import wb_pkg::*; (
   input  logic              CLK,
   input  logic              rst_n,
   input  logic              we,
   input  logic [DATA_W-1:0] mask,
   input  logic [DATA_W-1:0] data,
   output logic [DATA_W-1:0] flags
);

   logic [DATA_W-1:0] flags_q;
   logic [DATA_W-1:0] flags_next;

   // only the bits selected by the mask take the new value
   assign flags_next = (flags_q & ~mask) | (data & mask);

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         flags_q <= '0;
      end else if (we) begin
         flags_q <= flags_next;
      end
   end

   // same value feeds the jne/cmovc conditions and the forward path
   assign flags = flags_q;

endmodule

// File: verilog/wb_pkg.sv
package wb_pkg;

   // register file and datapath sizes
   localparam int GPR_COUNT  = 8;
   localparam int GPR_ADDR_W = $clog2(GPR_COUNT);
   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 32;

   // store buffer sizing
   localparam int STORE_DEPTH = 4;
   localparam int STORE_PTR_W = $clog2(STORE_DEPTH);
   localparam int STORE_CNT_W = $clog2(STORE_DEPTH + 1);

   // bit positions in the flags word
   localparam int FLAG_CF = 0;
   localparam int FLAG_ZF = 6;

   // one retired micro-op as handed over by execute
   typedef struct packed {
      logic                  valid;
      logic                  ld_gpr1;
      logic [GPR_ADDR_W-1:0] dr1;
      logic [DATA_W-1:0]     result_a;
      logic                  ld_gpr2;
      logic [GPR_ADDR_W-1:0] dr2;
      logic [DATA_W-1:0]     result_b;
      logic                  is_cmovc;
      logic                  ld_flags;
      logic [DATA_W-1:0]     flags_mask;
      logic [DATA_W-1:0]     flags_in;
      logic                  ld_eip;
      logic                  is_jne;
      logic [DATA_W-1:0]     neip;
      logic                  dcache_write;
      logic [ADDR_W-1:0]     address;
      logic                  is_halt;
   } wb_uop_t;

   // store request queued for the APB master
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } wb_store_t;

endpackage
